// File: hw/gfx_consts.svh
/*
  Shared constants for the graphics controller core.
  Raster sizes are tiny simulation values and match no real video mode.
  POS_WIDTH must hold both H_TOTAL-1 and V_TOTAL-1.
  PIXEL_LATENCY must be at least 2, because the VRAM read alone takes one cycle.
*/
`ifndef GFX_CONSTS_SVH
`define GFX_CONSTS_SVH

// Bus widths
`define MPU_ADDR_WIDTH 17    // MPU and VRAM word address
`define DATA_WIDTH 16        // Bus word
`define REG_SPACE_BIT 16     // Set = register space, clear = VRAM

// Register map
`define NUM_REGS 4
`define REG_CTRL 0
`define REG_BG_COLOR 1       // RGB565 background
`define REG_FB_BASE 2        // Frame buffer start, word address
`define REG_LINE_STRIDE 3    // Words per frame buffer line
`define CTRL_DISPLAY_EN 0    // Ctrl bit, fetch enable

// Horizontal geometry in pixels
`define H_ACTIVE 16
`define H_FRONT 2
`define H_SYNC 3
`define H_TOTAL 24

// Vertical geometry in lines
`define V_ACTIVE 8
`define V_FRONT 1
`define V_SYNC 2
`define V_TOTAL 12

`define POS_WIDTH 5          // Raster counter width

// Raster position to vga_rgb, in clocks
`define PIXEL_LATENCY 2

`endif

// File: hw/vram_pkg.sv
/*
  Types for the MPU bus and the VRAM bus.
  Both buses use word addresses, so byte enables pick the halves of one word.
*/
`default_nettype none

`include "gfx_consts.svh"

package vram_pkg;

  typedef logic [`MPU_ADDR_WIDTH-1:0] vram_addr_t;   // Word address
  typedef logic [`DATA_WIDTH-1:0] vram_data_t;       // Bus word
  typedef logic [`DATA_WIDTH/8-1:0] byte_en_t;       // Bit 0 = low byte

  // Control register number, low address bits in register space
  typedef logic [$clog2(`NUM_REGS)-1:0] reg_index_t;

endpackage

`default_nettype wire

// File: hw/video_pkg.sv
/*
  Types for the raster and the pixel path.
  rgb565_t is the frame buffer format. rgb666_t is the display output.
  sync_state_t is shared by the horizontal and the vertical axis.
*/
`default_nettype none

`include "gfx_consts.svh"

package video_pkg;

  typedef logic [`POS_WIDTH-1:0] pos_t;   // Raster counter, pixels or lines

  // Red in the top bits, blue in the bottom bits
  typedef logic [15:0] rgb565_t;
  typedef logic [17:0] rgb666_t;

  // Segments of one axis, in scan order
  typedef enum logic [1:0] {
    SYNC_ACTIVE,   // Visible area
    SYNC_FRONT,    // Front porch
    SYNC_PULSE,    // Sync asserted
    SYNC_BACK      // Back porch, wraps to active
  } sync_state_t;

endpackage

`default_nettype wire

// File: hw/mpu_port.sv
/*
  MPU side of the core. One access per cycle, exactly one of rd or wr set.
  Addresses with REG_SPACE_BIT set hit the control registers, others go to VRAM.
  Register reads return data 1 cycle later, VRAM reads 3 cycles later.
  A VRAM read return wins over a register read that lands in the same cycle.
  fb_base is a 16-bit register, so the frame buffer sits in the lower 64K words.
*/
`timescale 1ns/1ns
`default_nettype none

`include "gfx_consts.svh"

module mpu_port (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    mpu_en,
  input  wire                    mpu_rd,
  input  wire                    mpu_wr,
  input  wire vram_pkg::byte_en_t   mpu_be,
  input  wire vram_pkg::vram_addr_t mpu_addr,
  input  wire vram_pkg::vram_data_t mpu_wdata,
  output vram_pkg::vram_data_t   mpu_rdata,
  output logic                   mpu_vram_en,
  output logic                   mpu_vram_wr,
  output vram_pkg::byte_en_t     mpu_vram_be,
  output vram_pkg::vram_addr_t   mpu_vram_addr,
  output vram_pkg::vram_data_t   mpu_vram_wdata,
  input  wire vram_pkg::vram_data_t vram_rdata,
  output logic                   display_en,
  output video_pkg::rgb565_t     bg_color,
  output vram_pkg::vram_addr_t   fb_base,
  output vram_pkg::vram_data_t   line_stride
);

  logic                 reg_sel;    // Address in register space
  vram_pkg::reg_index_t reg_idx;
  logic                 reg_wr;
  logic                 reg_rd;
  logic                 vram_acc;   // Access to forward to VRAM
  logic                 rd_pend;    // VRAM read data valid this cycle

  vram_pkg::vram_data_t regs [`NUM_REGS];

  // Decode
  assign reg_sel  = mpu_addr[`REG_SPACE_BIT];
  assign reg_idx  = mpu_addr[$bits(vram_pkg::reg_index_t)-1:0];
  assign reg_wr   = mpu_en & reg_sel & mpu_wr;
  assign reg_rd   = mpu_en & reg_sel & mpu_rd;
  assign vram_acc = mpu_en & ~reg_sel & (mpu_rd | mpu_wr);

  // Control registers, byte lanes written separately
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_wr) begin
      if (mpu_be[0]) regs[reg_idx][7:0] <= mpu_wdata[7:0];
      if (mpu_be[1]) regs[reg_idx][15:8] <= mpu_wdata[15:8];
    end
  end

  // Forwarded strobes, one cycle behind the MPU
  always_ff @(posedge clk) begin
    if (rst) begin
      mpu_vram_en <= 1'b0;
      mpu_vram_wr <= 1'b0;
      rd_pend     <= 1'b0;
    end else begin
      mpu_vram_en <= vram_acc;
      mpu_vram_wr <= vram_acc & mpu_wr;
      rd_pend     <= mpu_vram_en & ~mpu_vram_wr;   // Memory answers one cycle after the bus
    end
  end

  // Forwarded payload
  always_ff @(posedge clk) begin
    if (vram_acc) begin
      mpu_vram_be    <= mpu_be;
      mpu_vram_addr  <= mpu_addr;
      mpu_vram_wdata <= mpu_wdata;
    end
  end

  // Read data holds until the next read completes
  always_ff @(posedge clk) begin
    if (rst) begin
      mpu_rdata <= '0;
    end else if (rd_pend) begin
      mpu_rdata <= vram_rdata;        // Third cycle after the strobe
    end else if (reg_rd) begin
      mpu_rdata <= regs[reg_idx];
    end
  end

  assign display_en  = regs[`REG_CTRL][`CTRL_DISPLAY_EN];
  assign bg_color    = regs[`REG_BG_COLOR];
  assign fb_base     = vram_pkg::vram_addr_t'(regs[`REG_FB_BASE]);   // Zero extended
  assign line_stride = regs[`REG_LINE_STRIDE];

endmodule

`default_nettype wire

// File: hw/display_timing.sv
/*
  Free-running raster generator. h_pos steps every clock, v_pos at line end.
  Syncs are active high. Blank flags are set outside the active area.
  After reset the scan starts at the top left of the active area.
*/
`timescale 1ns/1ns
`default_nettype none

`include "gfx_consts.svh"

module display_timing (
  input  wire                clk,
  input  wire                rst,
  output video_pkg::pos_t    h_pos,
  output video_pkg::pos_t    v_pos,
  output logic               hblank,
  output logic               vblank,
  output logic               hsync,
  output logic               vsync
);

  video_pkg::sync_state_t h_state;
  video_pkg::sync_state_t v_state;
  logic                   line_end;   // Last pixel of a line
  logic                   frame_end;  // Last line of a frame

  // Segment step for one axis, each limit is the last position of its segment
  function automatic video_pkg::sync_state_t next_state(
    input video_pkg::sync_state_t st,
    input video_pkg::pos_t        pos,
    input video_pkg::pos_t        act_last,
    input video_pkg::pos_t        front_last,
    input video_pkg::pos_t        sync_last,
    input video_pkg::pos_t        total_last
  );
    next_state = st;
    case (st)
      video_pkg::SYNC_ACTIVE: if (pos == act_last)   next_state = video_pkg::SYNC_FRONT;
      video_pkg::SYNC_FRONT:  if (pos == front_last) next_state = video_pkg::SYNC_PULSE;
      video_pkg::SYNC_PULSE:  if (pos == sync_last)  next_state = video_pkg::SYNC_BACK;
      default:                if (pos == total_last) next_state = video_pkg::SYNC_ACTIVE;
    endcase
  endfunction

  assign line_end  = (h_pos == `POS_WIDTH'(`H_TOTAL - 1));
  assign frame_end = (v_pos == `POS_WIDTH'(`V_TOTAL - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      h_pos   <= '0;
      v_pos   <= '0;
      h_state <= video_pkg::SYNC_ACTIVE;
      v_state <= video_pkg::SYNC_ACTIVE;
    end else begin
      h_pos   <= line_end ? '0 : h_pos + 1'b1;
      h_state <= next_state(h_state, h_pos,
                            `POS_WIDTH'(`H_ACTIVE - 1),
                            `POS_WIDTH'(`H_ACTIVE + `H_FRONT - 1),
                            `POS_WIDTH'(`H_ACTIVE + `H_FRONT + `H_SYNC - 1),
                            `POS_WIDTH'(`H_TOTAL - 1));
      if (line_end) begin   // Vertical axis moves once per line
        v_pos   <= frame_end ? '0 : v_pos + 1'b1;
        v_state <= next_state(v_state, v_pos,
                              `POS_WIDTH'(`V_ACTIVE - 1),
                              `POS_WIDTH'(`V_ACTIVE + `V_FRONT - 1),
                              `POS_WIDTH'(`V_ACTIVE + `V_FRONT + `V_SYNC - 1),
                              `POS_WIDTH'(`V_TOTAL - 1));
      end
    end
  end

  assign hblank = (h_state != video_pkg::SYNC_ACTIVE);
  assign vblank = (v_state != video_pkg::SYNC_ACTIVE);
  assign hsync  = (h_state == video_pkg::SYNC_PULSE);
  assign vsync  = (v_state == video_pkg::SYNC_PULSE);

endmodule

`default_nettype wire

// File: hw/pixel_fetch.sv
/*
  Frame buffer fetch and VRAM bus owner. The MPU always wins the bus.
  A fetch due in a cycle with an MPU access is dropped and shows bg_color.
  Address goes out with the raster position, data returns the next cycle.
  pixel and pixel_blank are valid one cycle after the position and are
  registered by video_out, giving PIXEL_LATENCY at the pins.
*/
`timescale 1ns/1ns
`default_nettype none

module pixel_fetch (
  input  wire                       clk,
  input  wire                       rst,
  input  wire video_pkg::pos_t      h_pos,
  input  wire video_pkg::pos_t      v_pos,
  input  wire                       hblank,
  input  wire                       vblank,
  input  wire                       display_en,
  input  wire video_pkg::rgb565_t   bg_color,
  input  wire vram_pkg::vram_addr_t fb_base,
  input  wire vram_pkg::vram_data_t line_stride,
  input  wire                       mpu_vram_en,
  input  wire                       mpu_vram_wr,
  input  wire vram_pkg::byte_en_t   mpu_vram_be,
  input  wire vram_pkg::vram_addr_t mpu_vram_addr,
  input  wire vram_pkg::vram_data_t mpu_vram_wdata,
  output logic                      vram_en,
  output logic                      vram_wr,
  output vram_pkg::byte_en_t        vram_be,
  output vram_pkg::vram_addr_t      vram_addr,
  output vram_pkg::vram_data_t      vram_wdata,
  input  wire vram_pkg::vram_data_t vram_rdata,
  output video_pkg::rgb565_t        pixel,
  output logic                      pixel_blank
);

  vram_pkg::vram_addr_t line_addr;    // Start of the current line
  vram_pkg::vram_addr_t fb_addr;      // Word for the current position
  logic                 fetch_due;
  logic                 fetch_lost;   // Bus taken by the MPU
  logic                 s1_blank;     // Stage 1 flags, aligned with vram_rdata
  logic                 s1_use_bg;

  // fb_base + y * stride + x, wraps at the address width
  assign line_addr = vram_pkg::vram_addr_t'(v_pos) * vram_pkg::vram_addr_t'(line_stride);
  assign fb_addr   = fb_base + line_addr + vram_pkg::vram_addr_t'(h_pos);

  assign fetch_due  = display_en & ~hblank & ~vblank;
  assign fetch_lost = fetch_due & mpu_vram_en;

  // Bus mux with MPU priority
  always_comb begin
    if (mpu_vram_en) begin
      vram_en   = 1'b1;
      vram_wr   = mpu_vram_wr;
      vram_be   = mpu_vram_be;
      vram_addr = mpu_vram_addr;
    end else begin
      vram_en   = fetch_due;
      vram_wr   = 1'b0;           // Fetches only read
      vram_be   = '1;             // Whole word
      vram_addr = fb_addr;
    end
  end

  assign vram_wdata = mpu_vram_wdata;   // Only the MPU ever writes

  // Flags travel with the read in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_blank  <= 1'b1;
      s1_use_bg <= 1'b1;
    end else begin
      s1_blank  <= hblank | vblank;
      s1_use_bg <= ~display_en | fetch_lost;   // Disabled or dropped fetch
    end
  end

  assign pixel       = s1_use_bg ? bg_color : vram_rdata;
  assign pixel_blank = s1_blank;

endmodule

`default_nettype wire

// File: hw/video_out.sv
/*
  Output stage. Syncs are delayed by PIXEL_LATENCY so they leave with their pixel.
  Blanked pixels are forced to zero. RGB565 widens to RGB666 by repeating the
  top bit of red and blue. All outputs come from registers cleared by reset.
*/
`timescale 1ns/1ns
`default_nettype none

`include "gfx_consts.svh"

module video_out (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     hsync,
  input  wire                     vsync,
  input  wire video_pkg::rgb565_t pixel,
  input  wire                     pixel_blank,
  output logic                    vga_hsync,
  output logic                    vga_vsync,
  output video_pkg::rgb666_t      vga_rgb
);

  logic [`PIXEL_LATENCY-1:0] hs_pipe;   // Sync delay lines, oldest at the top
  logic [`PIXEL_LATENCY-1:0] vs_pipe;
  video_pkg::rgb565_t        pix_q;
  logic                      blank_q;   // Blank flag in step with pix_q

  always_ff @(posedge clk) begin
    if (rst) begin
      hs_pipe <= '0;
      vs_pipe <= '0;
      blank_q <= 1'b1;          // Dark until the first pixel arrives
    end else begin
      hs_pipe <= {hs_pipe[`PIXEL_LATENCY-2:0], hsync};
      vs_pipe <= {vs_pipe[`PIXEL_LATENCY-2:0], vsync};
      blank_q <= pixel_blank;
    end
  end

  always_ff @(posedge clk) begin
    pix_q <= pixel;
  end

  assign vga_hsync = hs_pipe[`PIXEL_LATENCY-1];
  assign vga_vsync = vs_pipe[`PIXEL_LATENCY-1];

  // Red and blue get their MSB appended, green is already 6 bits
  assign vga_rgb = blank_q ? '0 : {pix_q[15:11], pix_q[15],
                                   pix_q[10:5],
                                   pix_q[4:0], pix_q[4]};

endmodule

`default_nettype wire

// File: hw/gfx_core.sv
/*
  Top level of the graphics controller core.
  The MPU bus and the VRAM bus are plain levels, all strobes active high.
  VRAM must be a synchronous memory with exactly one cycle of read latency.
  The MPU is never stalled; colliding display fetches show the background.
*/
`timescale 1ns/1ns
`default_nettype none

module gfx_core (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       mpu_en,
  input  wire                       mpu_rd,
  input  wire                       mpu_wr,
  input  wire vram_pkg::byte_en_t   mpu_be,
  input  wire vram_pkg::vram_addr_t mpu_addr,
  input  wire vram_pkg::vram_data_t mpu_wdata,
  output vram_pkg::vram_data_t      mpu_rdata,
  output logic                      vram_en,
  output logic                      vram_wr,
  output vram_pkg::byte_en_t        vram_be,
  output vram_pkg::vram_addr_t      vram_addr,
  output vram_pkg::vram_data_t      vram_wdata,
  input  wire vram_pkg::vram_data_t vram_rdata,
  output logic                      vga_hsync,
  output logic                      vga_vsync,
  output video_pkg::rgb666_t        vga_rgb
);

  // Forwarded MPU access to VRAM
  logic                 mpu_vram_en;
  logic                 mpu_vram_wr;
  vram_pkg::byte_en_t   mpu_vram_be;
  vram_pkg::vram_addr_t mpu_vram_addr;
  vram_pkg::vram_data_t mpu_vram_wdata;

  // Register values
  logic                 display_en;
  video_pkg::rgb565_t   bg_color;
  vram_pkg::vram_addr_t fb_base;
  vram_pkg::vram_data_t line_stride;

  // Raster
  video_pkg::pos_t      h_pos;
  video_pkg::pos_t      v_pos;
  logic                 hblank;
  logic                 vblank;
  logic                 hsync;
  logic                 vsync;

  video_pkg::rgb565_t   pixel;         // One cycle behind the raster
  logic                 pixel_blank;

  mpu_port mpu_port_inst (
    .clk, .rst,
    .mpu_en, .mpu_rd, .mpu_wr, .mpu_be, .mpu_addr, .mpu_wdata, .mpu_rdata,
    .mpu_vram_en, .mpu_vram_wr, .mpu_vram_be, .mpu_vram_addr, .mpu_vram_wdata,
    .vram_rdata,
    .display_en, .bg_color, .fb_base, .line_stride
  );

  display_timing display_timing_inst (
    .clk, .rst,
    .h_pos, .v_pos, .hblank, .vblank, .hsync, .vsync
  );

  pixel_fetch pixel_fetch_inst (
    .clk, .rst,
    .h_pos, .v_pos, .hblank, .vblank,
    .display_en, .bg_color, .fb_base, .line_stride,
    .mpu_vram_en, .mpu_vram_wr, .mpu_vram_be, .mpu_vram_addr, .mpu_vram_wdata,
    .vram_en, .vram_wr, .vram_be, .vram_addr, .vram_wdata, .vram_rdata,
    .pixel, .pixel_blank
  );

  video_out video_out_inst (
    .clk, .rst,
    .hsync, .vsync, .pixel, .pixel_blank,
    .vga_hsync, .vga_vsync, .vga_rgb
  );

endmodule

`default_nettype wire

// File: tests/gfx_core_checker.sv
/*
  Protocol and timing assertions, bound into gfx_core.
  The raster blank flags are delayed here by two registers to line up with vga_rgb.
  fail_count lets the testbench fold assertion failures into its verdict.
*/
`timescale 1ns/1ns
`default_nettype none

`include "gfx_consts.svh"

module gfx_core_checker (
  input wire        clk,
  input wire        rst,
  input wire        mpu_en,
  input wire        mpu_wr,
  input wire [16:0] mpu_addr,
  input wire        vram_en,
  input wire        vram_wr,
  input wire        hblank,
  input wire        vblank,
  input wire        vga_hsync,
  input wire        vga_vsync,
  input wire [17:0] vga_rgb
);

  int   fail_count = 0;
  int   hs_len;        // Consecutive high cycles of vga_hsync
  logic blank_d1;      // Raster blank, one cycle late
  logic blank_d2;      // Blank flag in step with vga_rgb

  always_ff @(posedge clk) begin
    if (rst) begin
      hs_len   <= 0;
      blank_d1 <= 1'b1;
      blank_d2 <= 1'b1;
    end else begin
      hs_len   <= vga_hsync ? hs_len + 1 : 0;
      blank_d1 <= hblank | vblank;
      blank_d2 <= blank_d1;
    end
  end

  // Every VRAM write comes from an MPU VRAM write one cycle earlier
  wr_forwarded: assert property (@(posedge clk) disable iff (rst)
      vram_wr |-> vram_en && $past(mpu_en && mpu_wr && !mpu_addr[`REG_SPACE_BIT]))
    else begin
      $error("vram_wr without an MPU VRAM write in the previous cycle");
      fail_count++;
    end

  hsync_width: assert property (@(posedge clk) disable iff (rst)
      $fell(vga_hsync) |-> hs_len == `H_SYNC)
    else begin
      $error("hsync pulse of %0d cycles", hs_len);
      fail_count++;
    end

  blank_dark: assert property (@(posedge clk) disable iff (rst) blank_d2 |-> vga_rgb == '0)
    else begin
      $error("vga_rgb not zero while blanked");
      fail_count++;
    end

  reset_quiet: assert property (@(posedge clk) $fell(rst) |->
      !vram_en && !vram_wr && !vga_hsync && !vga_vsync && vga_rgb == '0)
    else begin
      $error("outputs active right after reset");
      fail_count++;
    end

endmodule

bind gfx_core gfx_core_checker checker_inst (
  .clk, .rst, .mpu_en, .mpu_wr, .mpu_addr, .vram_en, .vram_wr, .hblank, .vblank,
  .vga_hsync, .vga_vsync, .vga_rgb
);

`default_nettype wire

// File: tests/gfx_core_tb.sv
/*
  Testbench for gfx_core. Holds a 64K-word VRAM with one cycle of read latency.
  Outputs are sampled on the falling edge, inputs change 2 ns after the rising edge.
  Output raster position is tracked from the rising edges of the syncs.
*/
`timescale 1ns/1ns
`default_nettype none

`include "gfx_consts.svh"

module gfx_core_tb;

  localparam int FRAME   = `H_TOTAL * `V_TOTAL;
  localparam int TIMEOUT = 6 * FRAME + 256;   // Six frames plus setup

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        mpu_en, mpu_rd, mpu_wr;
  logic [1:0]  mpu_be;
  logic [16:0] mpu_addr;
  logic [15:0] mpu_wdata, mpu_rdata;
  logic        vram_en, vram_wr;
  logic [1:0]  vram_be;
  logic [16:0] vram_addr;
  logic [15:0] vram_wdata, vram_rdata;
  logic        vga_hsync, vga_vsync;
  logic [17:0] vga_rgb;

  logic [15:0] vram_mem [65536];
  logic [15:0] lfsr = 16'd51;
  logic [15:0] cfg_bg, cfg_base, cfg_stride;   // What the testbench programmed
  logic [2:0]  lost_pipe = '0;                 // MPU VRAM strobes, 3 cycles to the pins
  logic        hs_prev = 1'b0, vs_prev = 1'b0;
  int errors = 0, tests_run = 0, tests_failed = 0, cyc = 0;
  int ox = -1, oy = -1;                        // Output position, -1 until locked
  int hs_rise_at = -1, vs_rise_at = -1, vs_rises = 0;
  int pix_mode = 0;                            // 0 off, 1 frame data, 2 background
  int collisions = 0;

  gfx_core gfx_core_inst (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cyc++;
    if (cyc >= TIMEOUT) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("TEST FAILED");
      $finish;
    end
  end

  // VRAM, writes at the edge, read data 2 ns later
  always @(posedge clk) begin : vram_model
    logic [15:0] rd_next;
    rd_next = vram_rdata;
    if (vram_en && vram_wr) begin
      if (vram_be[0]) vram_mem[vram_addr[15:0]][7:0] = vram_wdata[7:0];
      if (vram_be[1]) vram_mem[vram_addr[15:0]][15:8] = vram_wdata[15:8];
    end else if (vram_en) begin
      rd_next = vram_mem[vram_addr[15:0]];
    end
    #2 vram_rdata = rd_next;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hB400 : lfsr >> 1;
      v = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [17:0] expand565(input logic [15:0] w);
    return {w[15:11], w[15], w[10:5], w[4:0], w[4]};   // MSB repeat on red and blue
  endfunction

  function automatic logic [17:0] expected_rgb(input int x, input int y, input logic lost);
    logic [15:0] idx;
    idx = cfg_base + 16'(y) * cfg_stride + 16'(x);
    if (x >= `H_ACTIVE || y >= `V_ACTIVE) return '0;
    if (pix_mode == 2 || lost) return expand565(cfg_bg);
    return expand565(vram_mem[idx]);
  endfunction

  task automatic compare_value(input string name, input logic [17:0] got,
                               input logic [17:0] exp);
    assert (got == exp) else begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // One MPU access, returns in the cycle after the strobe
  task automatic mpu_access(input logic rd, input logic wr, input logic [1:0] be,
                            input logic [16:0] addr, input logic [15:0] wdata);
    @(posedge clk);
    #2;
    mpu_en = 1'b1;
    mpu_rd = rd;
    mpu_wr = wr;
    mpu_be = be;
    mpu_addr = addr;
    mpu_wdata = wdata;
    @(posedge clk);
    #2;
    mpu_en = 1'b0;
    mpu_rd = 1'b0;
    mpu_wr = 1'b0;
  endtask

  task automatic write_reg(input int idx, input logic [1:0] be, input logic [15:0] d);
    mpu_access(1'b0, 1'b1, be, 17'h10000 | 17'(idx), d);
  endtask

  task automatic wait_vsync_rise();
    int start;
    start = vs_rises;
    while (vs_rises == start) @(posedge clk);
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - err_start);
    end
  endtask

  always @(negedge clk) begin : raster_monitor
    logic        lost_now;
    logic [17:0] exp_rgb;
    lost_now = lost_pipe[2];
    lost_pipe = {lost_pipe[1:0], mpu_en & ~mpu_addr[`REG_SPACE_BIT]};
    if (!rst) begin
      if (vga_hsync && !hs_prev) begin
        if (hs_rise_at >= 0) assert (cyc - hs_rise_at == `H_TOTAL) else begin
          $display("hsync period was %0d cycles", cyc - hs_rise_at);
          errors++;
        end
        hs_rise_at = cyc;
        ox = `H_ACTIVE + `H_FRONT;
      end else if (ox >= 0) begin
        ox = (ox + 1) % `H_TOTAL;
        if (ox == 0 && oy >= 0) oy = (oy + 1) % `V_TOTAL;   // Next line
      end
      if (!vga_hsync && hs_prev) assert (cyc - hs_rise_at == `H_SYNC) else begin
        $display("hsync pulse was %0d cycles wide", cyc - hs_rise_at);
        errors++;
      end
      if (vga_vsync && !vs_prev) begin
        if (vs_rise_at >= 0) assert (cyc - vs_rise_at == FRAME) else begin
          $display("vsync period was %0d cycles", cyc - vs_rise_at);
          errors++;
        end
        vs_rise_at = cyc;
        oy = `V_ACTIVE + `V_FRONT;
        vs_rises++;
      end
      if (!vga_vsync && vs_prev) assert (cyc - vs_rise_at == `V_SYNC * `H_TOTAL) else begin
        $display("vsync pulse was %0d cycles wide", cyc - vs_rise_at);
        errors++;
      end
      hs_prev = vga_hsync;
      vs_prev = vga_vsync;
      if (pix_mode != 0 && oy >= 0) begin
        exp_rgb = expected_rgb(ox, oy, lost_now);
        if (lost_now && pix_mode == 1 && ox < `H_ACTIVE && oy < `V_ACTIVE) collisions++;
        assert (vga_rgb == exp_rgb) else begin
          $display("FAILED vga_rgb at (%0d,%0d): got %h expected %h", ox, oy, vga_rgb, exp_rgb);
          errors++;
        end
      end
    end
  end

  initial begin
    int          e;
    int          chk;
    logic [15:0] cur, d, old;
    logic [16:0] a;
    logic [1:0]  be;
    mpu_en = 1'b0;
    mpu_rd = 1'b0;
    mpu_wr = 1'b0;
    mpu_be = '0;
    mpu_addr = '0;
    mpu_wdata = '0;
    vram_rdata = '0;
    for (int i = 0; i < 65536; i++) vram_mem[i] = 16'(i * 16'h9e37) ^ 16'(i >> 5);
    cfg_base = 16'h0100;
    cfg_stride = 16'd20;
    cfg_bg = rand_bits(16);
    for (int y = 0; y < `V_ACTIVE; y++)
      for (int x = 0; x < `H_ACTIVE; x++)
        vram_mem[cfg_base + 16'(y) * cfg_stride + 16'(x)] = rand_bits(16);
    repeat (8) @(posedge clk);
    #2 rst = 1'b0;

    e = errors;   // Registers, merged byte lanes
    for (int idx = 0; idx < `NUM_REGS; idx++) begin
      cur = rand_bits(16);
      write_reg(idx, 2'b11, cur);
      for (int k = 0; k < 4; k++) begin
        be = 2'(k);
        d = rand_bits(16);
        write_reg(idx, be, d);
        if (be[0]) cur[7:0] = d[7:0];
        if (be[1]) cur[15:8] = d[15:8];
        mpu_access(1'b1, 1'b0, 2'b11, 17'h10000 | 17'(idx), '0);
        @(negedge clk);
        compare_value("mpu_rdata", mpu_rdata, cur);
      end
      write_reg(idx, 2'b11, '0);
    end
    report_test("registers", e);

    e = errors;   // VRAM writes and reads through the MPU
    for (int k = 1; k < 4; k++) begin
      a = 17'h09000 + 17'(rand_bits(8));
      d = rand_bits(16);
      be = 2'(k);
      old = vram_mem[a[15:0]];
      mpu_access(1'b0, 1'b1, be, a, d);
      @(negedge clk);   // Forwarded access on the bus now
      compare_value("vram_en", vram_en, 1'b1);
      compare_value("vram_wr", vram_wr, 1'b1);
      compare_value("vram_addr", vram_addr, a);
      compare_value("vram_be", vram_be, be);
      compare_value("vram_wdata", vram_wdata, d);
      @(negedge clk);
      compare_value("vram_mem", vram_mem[a[15:0]],
                    {be[1] ? d[15:8] : old[15:8], be[0] ? d[7:0] : old[7:0]});
      mpu_access(1'b1, 1'b0, 2'b11, a, '0);
      repeat (2) @(posedge clk);
      @(negedge clk);
      compare_value("mpu_rdata", mpu_rdata, vram_mem[a[15:0]]);
    end
    report_test("vram access", e);

    e = errors;   // Sync periods and widths are checked by the monitor
    while (vs_rises < 2) @(posedge clk);
    report_test("sync timing", e);

    e = errors;
    write_reg(`REG_FB_BASE, 2'b11, cfg_base);
    write_reg(`REG_LINE_STRIDE, 2'b11, cfg_stride);
    write_reg(`REG_BG_COLOR, 2'b11, cfg_bg);
    write_reg(`REG_CTRL, 2'b11, 16'h0001);
    pix_mode = 1;
    wait_vsync_rise();
    pix_mode = 0;
    report_test("pixel output", e);

    e = errors;
    write_reg(`REG_CTRL, 2'b11, 16'h0000);
    pix_mode = 2;
    wait_vsync_rise();
    pix_mode = 0;
    report_test("display disabled", e);

    e = errors;   // Random MPU writes outside the frame buffer
    write_reg(`REG_CTRL, 2'b11, 16'h0001);
    pix_mode = 1;
    chk = vs_rises;
    while (vs_rises == chk) begin
      @(posedge clk);
      #2;
      if (rand_bits(3) == 0) begin
        mpu_en = 1'b1;
        mpu_wr = 1'b1;
        mpu_be = 2'b11;
        mpu_addr = 17'h08000 | 17'(rand_bits(8));
        mpu_wdata = rand_bits(16);
      end else begin
        mpu_en = 1'b0;
        mpu_wr = 1'b0;
      end
    end
    mpu_en = 1'b0;
    mpu_wr = 1'b0;
    pix_mode = 0;
    assert (collisions > 0) else begin
      $display("No MPU write collided with an active pixel fetch");
      errors++;
    end
    report_test("contention", e);

    chk = gfx_core_inst.checker_inst.fail_count;
    $display("Tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, chk);
    if (tests_failed == 0 && chk == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+hw
hw/vram_pkg.sv
hw/video_pkg.sv
hw/mpu_port.sv
hw/display_timing.sv
hw/pixel_fetch.sv
hw/video_out.sv
hw/gfx_core.sv
tests/gfx_core_checker.sv
tests/gfx_core_tb.sv

// File: Makefile
# Verilator build and run for the graphics controller core

SIM = obj_dir/Vgfx_core_tb

all: run

$(SIM): build.f $(wildcard hw/*) $(wildcard tests/*)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module gfx_core_tb

run: $(SIM)
	./$(SIM) +verilator+error+limit+1000 | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module gfx_core_tb

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
